//--- carrierLoop.f
hdl/carrierLoopPkg.sv
hdl/loopCfgIf.sv
hdl/carrierLoopRegs.sv
hdl/loopFilter.sv
hdl/lockDetector.sv
hdl/carrierLoop.sv
verification/tbClockGen.sv
verification/carrierLoopTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
TOP       = carrierLoopTb
FILELIST  = carrierLoop.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS      = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulator output is kept in the log and searched for the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS)" $(LOG) || (echo "Simulation FAILED"; exit 1)
	@echo "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/carrierLoopTb.sv
`default_nettype none

module carrierLoopTb import carrierLoopPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod     = 40;
    localparam int driveDelay    = 5;
    localparam int resetCycles   = 10;
    localparam int numWrites     = 60;
    localparam int numStreams    = 8;
    localparam int streamLen     = 40;
    localparam int streamCycles  = 5 + streamLen + 3;
    localparam int plannedCycles = resetCycles + numWrites + (numWrites / 10 + 1) * 9
                                 + (numStreams + 10) * streamCycles + 200;

    logic                         clk;
    logic                         rstN;
    logic [addrWidth-1:0]         addr;
    logic [busWidth-1:0]          dataIn;
    logic [busWidth-1:0]          dataOut;
    logic                         cs;
    logic [3:0]                   wrLanes;
    logic signed [errorWidth-1:0] errorIn;
    logic                         errorValid;
    logic [busWidth-1:0]          loopOut;
    logic                         loopValid;
    logic                         lockStatus;

    logic [31:0]               lfsrState = 32'h67dd_47bc;
    logic [busWidth-1:0]       shadow [0:5];   // Register copies indexed by word address
    logic [busWidth-1:0]       accumModel;
    logic [lockCountWidth-1:0] runModel;
    logic [busWidth-1:0]       expQ [$];
    int                        dueQ [$];       // Cycle in which each expected output is due
    int                        cycleCount;

    tbClockGen #(.Period(clkPeriod)) clockGen (.clk(clk));

    carrierLoop #(.ErrorWidth(errorWidth)) dut (
        .clk(clk), .rstN(rstN), .addr(addr), .dataIn(dataIn), .dataOut(dataOut), .cs(cs),
        .wr0(wrLanes[0]), .wr1(wrLanes[1]), .wr2(wrLanes[2]), .wr3(wrLanes[3]),
        .errorIn(errorIn), .errorValid(errorValid), .loopOut(loopOut),
        .loopValid(loopValid), .lockStatus(lockStatus)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits      = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic logic [addrWidth-1:0] randomAddr();
        logic [31:0] pick;
        pick = randBits(4);
        if (pick[3]) return randBits(addrWidth);
        return {7'b0, pick[2:0], 2'b00};   // Mapped words plus the first unmapped one
    endfunction

    function automatic logic [errorWidth-1:0] errorNear(input int base, input int spread);
        int mag;
        mag = base + (randBits(12) % spread);
        if (randBits(1)) mag = -mag;
        return mag[errorWidth-1:0];
    endfunction

    function automatic logic [busWidth-1:0] fieldMask(input logic [addrWidth-1:0] a);
        case (a)
            addrControl:      return 32'h0000_031F;
            addrLeadLag:      return 32'hFF1F_FF1F;
            addrLockDetector: return 32'h0FFF_FFFF;
            addrUpperLimit, addrLowerLimit, addrLoopData: return '1;
            default:          return '0;
        endcase
    endfunction

    function automatic logic lockModel();
        return (shadow[5][15:0] != 0) && (runModel >= shadow[5][15:0]);
    endfunction

    function automatic logic [busWidth-1:0] readModel(input logic [addrWidth-1:0] a);
        if (a == addrControl) return shadow[0] | {lockModel(), 31'b0};
        if (a == addrIntegrator) return accumModel;
        if (fieldMask(a) != 0) return shadow[a[4:2]];
        return '0;
    endfunction

    function automatic logic [busWidth-1:0] scaleError(input logic [errorWidth-1:0] err,
            input logic [manWidth-1:0] man, input logic [expWidth-1:0] shift);
        logic [busWidth-1:0] wide;
        wide = {{(busWidth - errorWidth){err[errorWidth-1]}}, err};
        return (wide * {{(busWidth - manWidth){1'b0}}, man}) << shift;
    endfunction

    function automatic logic [busWidth-1:0] stepAccum(input logic [busWidth-1:0] lagTerm);
        longint sum;
        if (shadow[0][3]) return '0;
        if (shadow[0][9:8] == modeOpen || shadow[0][9:8] == modeHold) return accumModel;
        sum = longint'($signed(accumModel)) + longint'($signed(lagTerm));
        if (sum > longint'($signed(shadow[2]))) return shadow[2];
        if (sum < longint'($signed(shadow[3]))) return shadow[3];
        return sum[busWidth-1:0];
    endfunction

    task automatic abortRun();
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compareWord(input string name, input logic [busWidth-1:0] got,
            input logic [busWidth-1:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s got %h expected %h", name, got, expected);
            abortRun();
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("[FAIL] %s got %h expected %h", name, got, expected);
            abortRun();
        end
    endtask

    // One clock, then checks of everything the DUT produced at that edge
    task automatic cycle();
        @(posedge clk);
        #driveDelay;
        cycleCount++;
        compareBit("lockStatus", lockStatus, lockModel());
        if (dueQ.size() != 0 && dueQ[0] == cycleCount) begin
            if (!loopValid) begin
                $display("loopValid did not rise two edges after errorValid");
                abortRun();
            end else begin
                void'(dueQ.pop_front());
                compareWord("loopOut", loopOut, expQ.pop_front());
            end
        end else if (loopValid) begin
            $display("loopValid rose with no sample in flight");
            abortRun();
        end
    endtask

    task automatic busWrite(input logic [addrWidth-1:0] a, input logic [busWidth-1:0] d,
            input logic [3:0] lanes);
        logic [busWidth-1:0] mask;
        mask = fieldMask(a);
        cs = 1'b1;
        addr = a;
        dataIn = d;
        wrLanes = lanes;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i] && mask != 0) shadow[a[4:2]][8*i +: 8] = d[8*i +: 8] & mask[8*i +: 8];
        end
        cycle();
        cs = 1'b0;
        wrLanes = '0;
    endtask

    task automatic busRead(input logic [addrWidth-1:0] a, output logic [busWidth-1:0] value);
        cs = 1'b1;
        addr = a;
        cycle();
        value = dataOut;
        compareWord($sformatf("dataOut[%h]", a), dataOut, readModel(a));
        cs = 1'b0;
    endtask

    task automatic readAll();
        logic [busWidth-1:0] value;
        for (int i = 0; i < 8; i++) busRead(addrWidth'(4 * i), value);
        busRead(randomAddr(), value);
    endtask

    task automatic sample(input logic valid, input logic [errorWidth-1:0] err);
        logic [errorWidth-1:0] cond;
        logic [busWidth-1:0]   leadTerm;
        logic [busWidth-1:0]   lagTerm;
        int                    mag;
        errorValid = valid;
        errorIn = err;
        if (valid) begin
            cond = shadow[0][0] ? '0 : (shadow[0][1] ? -err : err);
            leadTerm = scaleError(cond, shadow[1][31:24], shadow[1][20:16]);
            lagTerm = scaleError(cond, shadow[1][15:8], shadow[1][4:0]);
            accumModel = stepAccum(lagTerm);
            expQ.push_back(shadow[0][9:8] == modeOpen ? shadow[4]
                                                      : shadow[4] + accumModel + leadTerm);
            dueQ.push_back(cycleCount + 2);
            mag = $signed(err);
            if (mag < 0) mag = -mag;
            if (mag >= int'(shadow[5][27:16])) runModel = '0;
            else if (runModel != '1) runModel++;
        end
        cycle();
        errorValid = 1'b0;
    endtask

    task automatic configure(input logic [busWidth-1:0] ctrl, input logic [busWidth-1:0] gains,
            input logic [busWidth-1:0] upper, input logic [busWidth-1:0] lower,
            input logic [busWidth-1:0] offset);
        busWrite(addrControl, ctrl, 4'hF);
        busWrite(addrLeadLag, gains, 4'hF);
        busWrite(addrUpperLimit, upper, 4'hF);
        busWrite(addrLowerLimit, lower, 4'hF);
        busWrite(addrLoopData, offset, 4'hF);
    endtask

    // Mostly back-to-back samples, then a drain and an integrator readback
    task automatic runStream(input int len, output logic [busWidth-1:0] accum);
        for (int i = 0; i < len; i++) sample(randBits(2) != 0, randBits(errorWidth));
        repeat (2) sample(1'b0, '0);
        busRead(addrIntegrator, accum);
    endtask

    initial begin
        #(2 * plannedCycles * clkPeriod);
        $display("watchdog timeout after %0d cycles", cycleCount);
        abortRun();
    end

    initial begin
        logic [busWidth-1:0] value;
        logic [busWidth-1:0] held;
        logic [31:0]         mode;
        int                  limit;
        int                  threshold;
        int                  runLen;
        rstN = 1'b0;
        cs = 1'b0;
        wrLanes = '0;
        addr = '0;
        dataIn = '0;
        errorIn = '0;
        errorValid = 1'b0;
        cycleCount = 0;
        accumModel = '0;
        runModel = '0;
        foreach (shadow[i]) shadow[i] = '0;
        shadow[2] = upperLimitReset;
        shadow[3] = lowerLimitReset;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        compareWord("loopOut", loopOut, '0);
        compareBit("loopValid", loopValid, 1'b0);
        compareWord("dataOut", dataOut, '0);   // Chip select low
        readAll();

        for (int i = 1; i <= numWrites; i++) begin
            busWrite(randomAddr(), randBits(32), randBits(4));
            if (i % 10 == 0) readAll();
        end

        for (int s = 0; s < numStreams; s++) begin
            mode = randBits(4);
            configure({22'b0, mode[1:0], 3'b0, mode[3], 1'b0, mode[2], 2'b0}, randBits(32),
                      upperLimitReset, lowerLimitReset, randBits(32));
            runStream(streamLen, value);
        end

        for (int s = 0; s < 4; s++) begin
            limit = randBits(12) + 1;
            configure(32'h0000_0100, randBits(32), limit, -limit, randBits(32));
            runStream(streamLen, value);
            if ($signed(value) > limit || $signed(value) < -limit) begin
                $display("integrator %h left the range +-%0d", value, limit);
                abortRun();
            end
        end
        busWrite(addrControl, 32'h0000_0108, 4'hF);   // Clear while tracking
        sample(1'b1, randBits(errorWidth));
        runStream(4, value);
        compareWord("integrator", value, '0);
        configure(32'h0000_0100, randBits(32), upperLimitReset, lowerLimitReset, randBits(32));
        runStream(10, held);
        busWrite(addrControl, 32'h0000_0200, 4'hF);
        runStream(streamLen, value);
        compareWord("integrator", value, held);

        configure(32'h0000_0101, randBits(32), upperLimitReset, lowerLimitReset, randBits(32));
        runStream(streamLen, value);
        configure(32'h0000_0102, randBits(32), upperLimitReset, lowerLimitReset, randBits(32));
        sample(1'b1, 16'h8000);
        runStream(streamLen, value);
        configure(32'h0000_0000, randBits(32), upperLimitReset, lowerLimitReset, randBits(32));
        runStream(streamLen, value);

        threshold = 200 + randBits(8);
        runLen = 4 + randBits(3);
        busWrite(addrLockDetector, {4'h0, threshold[11:0], runLen[15:0]}, 4'hF);
        sample(1'b1, errorNear(threshold, 1024));
        for (int r = -1; r <= 3; r += (r == 0) ? 3 : 1) begin
            repeat (runLen + r) sample(1'b1, errorNear(0, threshold));
            busRead(addrControl, value);
            sample(1'b1, errorNear(threshold, 1024));
        end
        busWrite(addrLockDetector, {4'h0, threshold[11:0], 16'h0}, 4'hF);
        repeat (runLen + 2) sample(1'b1, errorNear(0, threshold));
        busRead(addrControl, value);
        repeat (2) sample(1'b0, '0);

        if (dueQ.size() != 0) begin
            $display("%0d expected loop outputs never arrived", dueQ.size());
            abortRun();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/tbClockGen.sv
`default_nettype none

module tbClockGen #(
    parameter int Period = 40
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;   // Free-running, starts low
    end

endmodule

`default_nettype wire

//--- hdl/carrierLoop.sv
`default_nettype none

module carrierLoop import carrierLoopPkg::*; #(
    parameter int ErrorWidth = errorWidth
) (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire logic        [addrWidth-1:0]  addr,
    input  wire logic        [busWidth-1:0]   dataIn,
    output logic             [busWidth-1:0]   dataOut,
    input  wire logic                         cs,
    input  wire logic                         wr0,
    input  wire logic                         wr1,
    input  wire logic                         wr2,
    input  wire logic                         wr3,
    input  wire logic signed [ErrorWidth-1:0] errorIn,
    input  wire logic                         errorValid,
    output logic             [busWidth-1:0]   loopOut,
    output logic                              loopValid,
    output logic                              lockStatus
);

    logic [lockCountWidth-1:0] lockCount;
    logic [thresholdWidth-1:0] syncThreshold;

    loopCfgIf cfgBus ();

    carrierLoopRegs regs (
        .clk           (clk),
        .rstN          (rstN),
        .addr          (addr),
        .dataIn        (dataIn),
        .dataOut       (dataOut),
        .cs            (cs),
        .wr0           (wr0),
        .wr1           (wr1),
        .wr2           (wr2),
        .wr3           (wr3),
        .lockStatus    (lockStatus),
        .lockCount     (lockCount),
        .syncThreshold (syncThreshold),
        .cfg           (cfgBus.regs)
    );

    loopFilter #(
        .ErrorWidth (ErrorWidth)
    ) filter (
        .clk        (clk),
        .rstN       (rstN),
        .errorIn    (errorIn),
        .errorValid (errorValid),
        .loopOut    (loopOut),
        .loopValid  (loopValid),
        .cfg        (cfgBus.filter)
    );

    // Watches the raw error, ahead of any conditioning in the filter
    lockDetector #(
        .ErrorWidth (ErrorWidth)
    ) lockDet (
        .clk           (clk),
        .rstN          (rstN),
        .errorIn       (errorIn),
        .errorValid    (errorValid),
        .lockCount     (lockCount),
        .syncThreshold (syncThreshold),
        .lockStatus    (lockStatus)
    );

endmodule

`default_nettype wire

//--- hdl/lockDetector.sv
`default_nettype none

module lockDetector import carrierLoopPkg::*; #(
    parameter int ErrorWidth = errorWidth
) (
    input  wire logic                             clk,
    input  wire logic                             rstN,
    input  wire logic signed [ErrorWidth-1:0]     errorIn,
    input  wire logic                             errorValid,
    input  wire logic        [lockCountWidth-1:0] lockCount,
    input  wire logic        [thresholdWidth-1:0] syncThreshold,
    output logic                                  lockStatus
);

    logic [ErrorWidth-1:0]     absError;
    logic                      smallError;
    logic [lockCountWidth-1:0] runCount;

    // Unsigned magnitude, so the most negative error still compares as large
    assign absError   = errorIn[ErrorWidth-1] ? -errorIn : errorIn;
    assign smallError = absError < syncThreshold;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            runCount <= '0;
        end else if (errorValid) begin
            if (!smallError) begin
                runCount <= '0;
            end else if (runCount != '1) begin
                runCount <= runCount + 1'b1;   // Saturates at full scale
            end
        end
    end

    // A zero count disables lock indication
    assign lockStatus = (runCount >= lockCount) && (lockCount != '0);

endmodule

`default_nettype wire

//--- hdl/loopFilter.sv
`default_nettype none

module loopFilter import carrierLoopPkg::*; #(
    parameter int ErrorWidth = errorWidth
) (
    input  wire logic                         clk,
    input  wire logic                         rstN,
    input  wire logic signed [ErrorWidth-1:0] errorIn,
    input  wire logic                         errorValid,
    output logic             [busWidth-1:0]   loopOut,
    output logic                              loopValid,
    loopCfgIf.filter                          cfg
);

    logic signed [ErrorWidth-1:0] condError;
    logic        [busWidth-1:0]   leadTerm;
    logic        [busWidth-1:0]   lagTerm;
    logic                         stage1Valid;
    logic signed [busWidth:0]     trackSum;
    logic signed [busWidth:0]     upperWide;
    logic signed [busWidth:0]     lowerWide;
    logic        [busWidth-1:0]   nextAccum;

    // Signed error times unsigned mantissa, scaled by a power of two
    function automatic logic [busWidth-1:0] gainTerm(
        input logic signed [ErrorWidth-1:0] err,
        input logic        [manWidth-1:0]   man,
        input logic        [expWidth-1:0]   exponent
    );
        logic signed [busWidth-1:0] product;
        product = err * $signed({1'b0, man});
        return product << exponent;
    endfunction

    always_comb begin
        if (cfg.zeroError) begin
            condError = '0;
        end else if (cfg.invertError) begin
            condError = -errorIn;   // Most negative input wraps to itself
        end else begin
            condError = errorIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stage1Valid <= 1'b0;
        end else begin
            stage1Valid <= errorValid;
        end
    end

    always_ff @(posedge clk) begin
        if (errorValid) begin
            leadTerm <= gainTerm(condError, cfg.leadMan, cfg.leadExp);
            lagTerm  <= gainTerm(condError, cfg.lagMan, cfg.lagExp);
        end
    end

    // Integrator step with signed saturation one bit wider than the bus
    always_comb begin
        upperWide = $signed({cfg.upperLimit[busWidth-1], cfg.upperLimit});
        lowerWide = $signed({cfg.lowerLimit[busWidth-1], cfg.lowerLimit});
        trackSum  = $signed({cfg.lagAccum[busWidth-1], cfg.lagAccum})
                  + $signed({lagTerm[busWidth-1], lagTerm});
        case (cfg.acqTrackControl)
            modeOpen, modeHold: nextAccum = cfg.lagAccum;
            default: begin   // Track, also taken by the spare code 3
                if (trackSum > upperWide) begin
                    nextAccum = cfg.upperLimit;
                end else if (trackSum < lowerWide) begin
                    nextAccum = cfg.lowerLimit;
                end else begin
                    nextAccum = trackSum[busWidth-1:0];
                end
            end
        endcase
        if (cfg.clearAccum) begin
            nextAccum = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            loopValid    <= 1'b0;
            loopOut      <= '0;
            cfg.lagAccum <= '0;
        end else begin
            loopValid <= stage1Valid;
            if (stage1Valid) begin
                cfg.lagAccum <= nextAccum;
                if (cfg.acqTrackControl == modeOpen) begin
                    loopOut <= cfg.loopData;   // Open loop drives the NCO at its centre word
                end else begin
                    loopOut <= cfg.loopData + nextAccum + leadTerm;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/carrierLoopRegs.sv
`default_nettype none

module carrierLoopRegs import carrierLoopPkg::*; (
    input  wire logic                      clk,
    input  wire logic                      rstN,
    input  wire logic [addrWidth-1:0]      addr,
    input  wire logic [busWidth-1:0]       dataIn,
    output logic      [busWidth-1:0]       dataOut,
    input  wire logic                      cs,
    input  wire logic                      wr0,
    input  wire logic                      wr1,
    input  wire logic                      wr2,
    input  wire logic                      wr3,
    input  wire logic                      lockStatus,
    output logic      [lockCountWidth-1:0] lockCount,
    output logic      [thresholdWidth-1:0] syncThreshold,
    loopCfgIf.regs                         cfg
);

    logic       ctrl2;
    logic       ctrl4;
    logic [3:0] byteEn;

    assign byteEn = {wr3, wr2, wr1, wr0};

    function automatic logic [busWidth-1:0] mergeBytes(
        input logic [busWidth-1:0] oldWord,
        input logic [busWidth-1:0] newWord,
        input logic [3:0]          lanes
    );
        logic [busWidth-1:0] merged;
        merged = oldWord;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                merged[8*i +: 8] = newWord[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfg.zeroError       <= 1'b0;
            cfg.invertError     <= 1'b0;
            ctrl2               <= 1'b0;
            cfg.clearAccum      <= 1'b0;
            ctrl4               <= 1'b0;
            cfg.acqTrackControl <= modeOpen;
            cfg.lagExp          <= '0;
            cfg.lagMan          <= '0;
            cfg.leadExp         <= '0;
            cfg.leadMan         <= '0;
            cfg.upperLimit      <= upperLimitReset;
            cfg.lowerLimit      <= lowerLimitReset;
            cfg.loopData        <= '0;
            lockCount           <= '0;
            syncThreshold       <= '0;
        end else if (cs) begin
            case (addr)
                addrControl: begin
                    if (wr0) begin
                        cfg.zeroError   <= dataIn[0];
                        cfg.invertError <= dataIn[1];
                        ctrl2           <= dataIn[2];   // Spare storage bit
                        cfg.clearAccum  <= dataIn[3];
                        ctrl4           <= dataIn[4];   // Spare storage bit
                    end
                    if (wr1) cfg.acqTrackControl <= dataIn[9:8];
                end
                addrLeadLag: begin
                    if (wr0) cfg.lagExp <= dataIn[4:0];
                    if (wr1) cfg.lagMan <= dataIn[15:8];
                    if (wr2) cfg.leadExp <= dataIn[20:16];
                    if (wr3) cfg.leadMan <= dataIn[31:24];
                end
                addrUpperLimit: cfg.upperLimit <= mergeBytes(cfg.upperLimit, dataIn, byteEn);
                addrLowerLimit: cfg.lowerLimit <= mergeBytes(cfg.lowerLimit, dataIn, byteEn);
                addrLoopData:   cfg.loopData <= mergeBytes(cfg.loopData, dataIn, byteEn);
                addrLockDetector: begin
                    if (wr0) lockCount[7:0] <= dataIn[7:0];
                    if (wr1) lockCount[15:8] <= dataIn[15:8];
                    if (wr2) syncThreshold[7:0] <= dataIn[23:16];
                    if (wr3) syncThreshold[11:8] <= dataIn[27:24];   // Upper nibble of lane 3 unused
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        dataOut = '0;
        if (cs) begin
            case (addr)
                addrControl: begin
                    dataOut = {lockStatus, 21'b0, cfg.acqTrackControl, 3'b0,
                               ctrl4, cfg.clearAccum, ctrl2, cfg.invertError, cfg.zeroError};
                end
                addrLeadLag: begin
                    dataOut = {cfg.leadMan, 3'b0, cfg.leadExp, cfg.lagMan, 3'b0, cfg.lagExp};
                end
                addrUpperLimit:   dataOut = cfg.upperLimit;
                addrLowerLimit:   dataOut = cfg.lowerLimit;
                addrLoopData:     dataOut = cfg.loopData;
                addrLockDetector: dataOut = {4'h0, syncThreshold, lockCount};
                addrIntegrator:   dataOut = cfg.lagAccum;   // Live integrator value
                default:          dataOut = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/loopCfgIf.sv
`default_nettype none

interface loopCfgIf import carrierLoopPkg::*; ();

    logic                zeroError;
    logic                invertError;
    logic                clearAccum;
    logic [1:0]          acqTrackControl;
    logic [expWidth-1:0] leadExp;
    logic [manWidth-1:0] leadMan;
    logic [expWidth-1:0] lagExp;
    logic [manWidth-1:0] lagMan;
    logic [busWidth-1:0] upperLimit;
    logic [busWidth-1:0] lowerLimit;
    logic [busWidth-1:0] loopData;   // NCO centre word
    logic [busWidth-1:0] lagAccum;   // Integrator, read back through the register block

    modport regs (
        output zeroError, invertError, clearAccum, acqTrackControl,
        output leadExp, leadMan, lagExp, lagMan,
        output upperLimit, lowerLimit, loopData,
        input  lagAccum
    );

    modport filter (
        input  zeroError, invertError, clearAccum, acqTrackControl,
        input  leadExp, leadMan, lagExp, lagMan,
        input  upperLimit, lowerLimit, loopData,
        output lagAccum
    );

endinterface

`default_nettype wire

//--- hdl/carrierLoopPkg.sv
`default_nettype none

package carrierLoopPkg;

    // Bus and datapath widths
    localparam int busWidth       = 32;
    localparam int addrWidth      = 12;
    localparam int errorWidth     = 16;
    localparam int manWidth       = 8;
    localparam int expWidth       = 5;
    localparam int lockCountWidth = 16;
    localparam int thresholdWidth = 12;

    // Register byte addresses
    localparam logic [addrWidth-1:0] addrControl      = 12'h000;
    localparam logic [addrWidth-1:0] addrLeadLag      = 12'h004;
    localparam logic [addrWidth-1:0] addrUpperLimit   = 12'h008;
    localparam logic [addrWidth-1:0] addrLowerLimit   = 12'h00C;
    localparam logic [addrWidth-1:0] addrLoopData     = 12'h010;
    localparam logic [addrWidth-1:0] addrLockDetector = 12'h014;
    localparam logic [addrWidth-1:0] addrIntegrator   = 12'h018;

    // Integrator limits start at the full signed range
    localparam logic [busWidth-1:0] upperLimitReset = 32'h7FFF_FFFF;
    localparam logic [busWidth-1:0] lowerLimitReset = 32'h8000_0000;

    // Values of acqTrackControl, where 3 behaves as track
    localparam logic [1:0] modeOpen  = 2'd0;
    localparam logic [1:0] modeTrack = 2'd1;
    localparam logic [1:0] modeHold  = 2'd2;

endpackage

`default_nettype wire
